// File: dv/audio_tb.sv
`timescale 1ns/1ps

module audio_tb;

	localparam int QUEUE_DEPTH = 8;
	localparam int DEFAULT_RELOAD = 5;
	localparam int CLOCK_NS = 4;
	localparam int HALF = QUEUE_DEPTH / 2;
	localparam int MAX_STEPS = 32;

	// Table operations
	localparam int OP_WRITE = 0;
	localparam int OP_READ = 1; // Compared with the expected column
	localparam int OP_PUSH = 2; // Data column is the frame count
	localparam int OP_PUSH_FULL = 3; // Push into a full queue, must wait for a pop
	localparam int OP_DRAIN = 4;
	localparam int OP_LEVEL = 5; // Fill level against the model
	localparam int OP_GAPS = 6; // Last N strobe gaps, in cycles

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	logic [cpu_bus_pkg::ADDR_W-1:0] i_address;
	logic [cpu_bus_pkg::DATA_W-1:0] i_wdata;
	logic [cpu_bus_pkg::DATA_W-1:0] o_rdata;
	logic o_ready;
	logic o_interrupt;
	logic [audio_pkg::SAMPLE_W-1:0] o_sample_left;
	logic [audio_pkg::SAMPLE_W-1:0] o_sample_right;
	logic o_sample_strobe;

	int step_op [MAX_STEPS];
	logic [cpu_bus_pkg::ADDR_W-1:0] step_addr [MAX_STEPS];
	logic [31:0] step_data [MAX_STEPS];
	logic [31:0] step_expect [MAX_STEPS];
	int step_count = 0;
	bit table_ready = 0;
	int max_reload = DEFAULT_RELOAD;

	// Model of the queue contents and output history
	logic [audio_pkg::FRAME_W-1:0] model_frames [$];
	time strobe_times [$];
	int pushed_count = 0;
	int strobe_count = 0;
	int irq_expected = 0;
	int irq_count = 0;
	bit irq_pending = 0; // A fall through half-full awaits its interrupt
	int error_count = 0;
	int check_count = 0;

	audio_subsystem #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.DEFAULT_RELOAD(DEFAULT_RELOAD)
	) dut0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_interrupt(o_interrupt),
		.o_sample_left(o_sample_left),
		.o_sample_right(o_sample_right),
		.o_sample_strobe(o_sample_strobe)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_NS / 2) i_clock = ~i_clock;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic add_step(input int op, input logic [cpu_bus_pkg::ADDR_W-1:0] addr,
			input logic [31:0] data, input logic [31:0] expected);
		step_op[step_count] = op;
		step_addr[step_count] = addr;
		step_data[step_count] = data;
		step_expect[step_count] = expected;
		step_count++;
		if (op == OP_WRITE && addr == cpu_bus_pkg::REG_RELOAD && int'(data) > max_reload) begin
			max_reload = data;
		end
	endtask

	task automatic load_table();
		add_step(OP_READ, cpu_bus_pkg::REG_RELOAD, 0, DEFAULT_RELOAD);
		add_step(OP_WRITE, cpu_bus_pkg::REG_RELOAD, 3, 0);
		add_step(OP_READ, cpu_bus_pkg::REG_RELOAD, 0, 3);
		add_step(OP_READ, 4'h7, 0, 0); // Unmapped
		add_step(OP_WRITE, 4'h7, 32'hdead_beef, 0);
		add_step(OP_READ, cpu_bus_pkg::REG_RELOAD, 0, 3);
		add_step(OP_READ, cpu_bus_pkg::REG_QUEUE, 0, 0);
		add_step(OP_PUSH, 0, 6, 0); // Burst at reload 3
		add_step(OP_DRAIN, 0, 0, 0);
		add_step(OP_GAPS, 0, 5, 4);
		add_step(OP_WRITE, cpu_bus_pkg::REG_RELOAD, 30, 0);
		add_step(OP_PUSH, 0, 7, 0); // Prefill while the pacer is busy
		add_step(OP_WRITE, cpu_bus_pkg::REG_RELOAD, 0, 0);
		add_step(OP_DRAIN, 0, 0, 0);
		add_step(OP_GAPS, 0, 5, 1);
		add_step(OP_WRITE, cpu_bus_pkg::REG_RELOAD, 200, 0);
		add_step(OP_PUSH, 0, 9, 0); // One popped, eight fill the queue
		add_step(OP_LEVEL, 0, 0, 0);
		add_step(OP_PUSH_FULL, 0, 1, 0);
		add_step(OP_LEVEL, 0, 0, 0);
		add_step(OP_WRITE, cpu_bus_pkg::REG_RELOAD, 10, 0);
		add_step(OP_DRAIN, 0, 0, 0);
	endtask

	// One request/ready access
	task automatic bus_access(input logic rw, input logic [cpu_bus_pkg::ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge i_clock);
		#1;
		i_request = 1'b1;
		i_rw = rw;
		i_address = addr;
		i_wdata = wdata;
		do begin
			@(posedge i_clock);
			#1;
		end while (!o_ready);
		rdata = o_rdata;
		i_request = 1'b0;
		do begin
			@(posedge i_clock);
			#1;
		end while (o_ready);
	endtask

	task automatic push_frames(input int n);
		logic [31:0] frame;
		logic [31:0] ignored_rdata;
		for (int k = 0; k < n; k++) begin
			frame = $urandom();
			bus_access(1'b1, cpu_bus_pkg::REG_QUEUE, frame, ignored_rdata);
			model_frames.push_back(frame);
			pushed_count++;
		end
	endtask

	task automatic drain_queue();
		int waited;
		int limit;
		waited = 0;
		limit = (pushed_count - strobe_count + 1) * (max_reload + 2);
		while (strobe_count < pushed_count && waited < limit) begin
			@(posedge i_clock);
			#1;
			waited++;
		end
		if (strobe_count < pushed_count) begin
			report_failure($sformatf("Missing strobe, %0d written frames never came out",
				pushed_count - strobe_count));
		end
	endtask

	task automatic check_gaps(input int n, input int gap);
		int last;
		last = strobe_times.size() - 1;
		if (last < n) begin
			report_failure("Too few strobes to check their spacing");
		end else begin
			for (int k = last - n + 1; k <= last; k++) begin
				check_value("strobe spacing", gap, (strobe_times[k] - strobe_times[k-1]) / CLOCK_NS);
			end
		end
	endtask

	// Output monitor, sampled mid-cycle
	always @(negedge i_clock) begin : strobe_monitor
		logic [audio_pkg::FRAME_W-1:0] frame;
		int level_before;
		if (!i_reset && o_sample_strobe) begin
			strobe_times.push_back($time);
			level_before = pushed_count - strobe_count;
			strobe_count++;
			if (model_frames.size() == 0) begin
				report_failure("Strobe with no written frame left to output");
			end else begin
				frame = model_frames.pop_front();
				check_value("o_sample_left", frame[31:16], o_sample_left); // Upper half
				check_value("o_sample_right", frame[15:0], o_sample_right);
			end
			if (irq_pending) begin
				report_failure("Interrupt never fired after the level fell to half-full");
			end
			irq_pending = (level_before > HALF) && (level_before - 1 <= HALF);
			if (irq_pending) begin
				irq_expected++;
			end
		end
		if (!i_reset && o_interrupt) begin
			irq_count++;
			if (irq_pending) begin
				irq_pending = 0;
			end else begin
				report_failure("Interrupt fired without a fall through half-full");
			end
		end
	end

	initial begin
		logic [31:0] rdata;
		int strobes_before;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		void'($urandom(32'h192a_297d));
		load_table();
		table_ready = 1;
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		check_value("o_ready", 0, o_ready);
		check_value("o_sample_strobe", 0, o_sample_strobe);
		check_value("o_sample_left", 0, o_sample_left);

		for (int i = 0; i < step_count; i++) begin
			case (step_op[i])
				OP_WRITE: bus_access(1'b1, step_addr[i], step_data[i], rdata);
				OP_READ: begin
					bus_access(1'b0, step_addr[i], 0, rdata);
					check_value("o_rdata", step_expect[i], rdata);
				end
				OP_PUSH: push_frames(step_data[i]);
				OP_PUSH_FULL: begin
					strobes_before = strobe_count;
					push_frames(step_data[i]);
					@(negedge i_clock);
					#1;
					if (strobe_count == strobes_before) begin
						report_failure("Write to a full queue completed before any frame was popped");
					end
				end
				OP_DRAIN: drain_queue();
				OP_LEVEL: begin
					bus_access(1'b0, cpu_bus_pkg::REG_QUEUE, 0, rdata);
					check_value("queue level", pushed_count - strobe_count, rdata);
				end
				OP_GAPS: check_gaps(step_data[i], step_expect[i]);
				default: report_failure("Unknown operation in the stimulus table");
			endcase
		end

		repeat (4) @(posedge i_clock);
		check_value("strobe count", pushed_count, strobe_count);
		check_value("interrupt count", irq_expected, irq_count);
		if (irq_pending) begin
			report_failure("Interrupt never fired after the last fall through half-full");
		end
		if (irq_expected == 0) begin
			report_failure("The queue never fell through half-full");
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		longint limit_ns;
		int frames;
		wait (table_ready);
		frames = 0;
		for (int i = 0; i < step_count; i++) begin
			if (step_op[i] == OP_PUSH || step_op[i] == OP_PUSH_FULL) begin
				frames += step_data[i];
			end
		end
		limit_ns = step_count * 40 + frames * (max_reload + 2) * CLOCK_NS + 1000;
		#(limit_ns);
		$display("Timeout, the run did not finish within %0d ns", limit_ns);
		$display("sim failed");
		$finish;
	end

endmodule

// File: files.f
hdl/cpu_bus_pkg.sv
hdl/audio_pkg.sv
hdl/sample_fifo.sv
hdl/audio_regs.sv
hdl/sample_pacer.sv
hdl/audio_subsystem.sv
dv/audio_tb.sv

// File: hdl/audio_pkg.sv
package audio_pkg;

	// One channel sample
	localparam int SAMPLE_W = 16;

	// Stereo frame, left sample in the upper half
	localparam int FRAME_W = 2 * SAMPLE_W;

	// Output period counter
	localparam int RELOAD_W = 32;

	// A reload of zero outputs one frame per cycle
	// A reload of N spaces the strobes N + 1 cycles apart

endpackage

// File: hdl/audio_regs.sv
`timescale 1ns/1ps

module audio_regs #(
	parameter int QUEUE_DEPTH = 4096,
	parameter int DEFAULT_RELOAD = 4536
)(
	input  logic i_clock,
	input  logic i_reset,

	// CPU side
	input  logic i_request,
	input  logic i_rw, // 1 = write
	input  logic [cpu_bus_pkg::ADDR_W-1:0] i_address,
	input  logic [cpu_bus_pkg::DATA_W-1:0] i_wdata,
	output logic [cpu_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,

	// Queue side
	input  logic i_queue_full,
	input  logic [$clog2(QUEUE_DEPTH):0] i_queue_level,
	output logic o_queue_write,

	output logic [audio_pkg::RELOAD_W-1:0] o_reload,
	output logic o_interrupt
);
	localparam int LEVEL_W = $clog2(QUEUE_DEPTH) + 1;
	localparam logic [LEVEL_W-1:0] HALF_LEVEL = LEVEL_W'(QUEUE_DEPTH / 2);

	logic access_start;
	logic above_half;
	logic [1:0] half_history;

	// New access, not yet acknowledged
	assign access_start = i_request && !o_ready;

	// Handshake, queue push and reload register
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready       <= 1'b0;
			o_queue_write <= 1'b0;
			o_reload      <= audio_pkg::RELOAD_W'(DEFAULT_RELOAD);
		end else begin
			o_queue_write <= 1'b0; // Single cycle pulse
			if (access_start) begin
				if (i_rw) begin
					case (i_address)
						cpu_bus_pkg::REG_QUEUE: begin
							// Stall until there is room
							if (!i_queue_full) begin
								o_queue_write <= 1'b1;
								o_ready       <= 1'b1;
							end
						end
						cpu_bus_pkg::REG_RELOAD: begin
							o_reload <= i_wdata[audio_pkg::RELOAD_W-1:0];
							o_ready  <= 1'b1;
						end
						default: begin
							o_ready <= 1'b1; // Unmapped, no effect
						end
					endcase
				end else begin
					o_ready <= 1'b1; // Reads never stall
				end
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
		end
	end

	// Read data, sampled with the access that asks for it
	always_ff @(posedge i_clock) begin
		if (access_start && !i_rw) begin
			case (i_address)
				cpu_bus_pkg::REG_QUEUE:  o_rdata <= cpu_bus_pkg::DATA_W'(i_queue_level);
				cpu_bus_pkg::REG_RELOAD: o_rdata <= cpu_bus_pkg::DATA_W'(o_reload);
				default:                 o_rdata <= '0;
			endcase
		end
	end

	// Half-empty detection
	assign above_half = (i_queue_level > HALF_LEVEL);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			half_history <= 2'b00;
		end else begin
			half_history <= {half_history[0], above_half};
		end
	end

	// Above last cycle, at or below now
	assign o_interrupt = (half_history == 2'b10);

endmodule

// File: hdl/audio_subsystem.sv
`timescale 1ns/1ps

module audio_subsystem #(
	parameter int QUEUE_DEPTH = 4096, // Frames, power of two
	parameter int DEFAULT_RELOAD = 4536
)(
	input  logic i_clock,
	input  logic i_reset,

	// CPU register port
	input  logic i_request,
	input  logic i_rw,
	input  logic [cpu_bus_pkg::ADDR_W-1:0] i_address,
	input  logic [cpu_bus_pkg::DATA_W-1:0] i_wdata,
	output logic [cpu_bus_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	// DAC side
	output logic [audio_pkg::SAMPLE_W-1:0] o_sample_left,
	output logic [audio_pkg::SAMPLE_W-1:0] o_sample_right,
	output logic o_sample_strobe
);
	logic queue_write;
	logic queue_read;
	logic queue_full;
	logic queue_empty;
	logic [$clog2(QUEUE_DEPTH):0] queue_level;
	logic [audio_pkg::FRAME_W-1:0] queue_frame;
	logic [audio_pkg::RELOAD_W-1:0] reload_value;

	audio_regs #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.DEFAULT_RELOAD(DEFAULT_RELOAD)
	) regs0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.i_queue_full(queue_full),
		.i_queue_level(queue_level),
		.o_queue_write(queue_write),
		.o_reload(reload_value),
		.o_interrupt(o_interrupt)
	);

	// Frame data comes straight from the CPU write bus
	sample_fifo #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) fifo0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(queue_write),
		.i_wdata(i_wdata[audio_pkg::FRAME_W-1:0]),
		.i_read(queue_read),
		.o_rdata(queue_frame),
		.o_empty(queue_empty),
		.o_full(queue_full),
		.o_level(queue_level)
	);

	sample_pacer pacer0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_reload(reload_value),
		.i_queue_empty(queue_empty),
		.o_queue_read(queue_read),
		.i_frame(queue_frame),
		.o_sample_left(o_sample_left),
		.o_sample_right(o_sample_right),
		.o_sample_strobe(o_sample_strobe)
	);

endmodule

// File: hdl/cpu_bus_pkg.sv
package cpu_bus_pkg;

	// CPU register bus
	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;

	// Register map
	// Write pushes a stereo frame, read returns the fill level
	localparam logic [ADDR_W-1:0] REG_QUEUE = 4'h0;

	// Output period in clock cycles
	localparam logic [ADDR_W-1:0] REG_RELOAD = 4'h1;

	// Every other address reads zero and ignores writes

endpackage

// File: hdl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo #(
	parameter int QUEUE_DEPTH = 4096 // Power of two
)(
	input  logic i_clock,
	input  logic i_reset,

	input  logic i_write,
	input  logic [audio_pkg::FRAME_W-1:0] i_wdata,
	input  logic i_read,
	output logic [audio_pkg::FRAME_W-1:0] o_rdata,

	output logic o_empty,
	output logic o_full,
	output logic [$clog2(QUEUE_DEPTH):0] o_level
);
	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	logic [audio_pkg::FRAME_W-1:0] mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_write;
	logic do_read;

	// Overflow and underflow requests are dropped
	assign do_write = i_write && !o_full;
	assign do_read  = i_read && !o_empty;

	assign o_empty = (count == '0);
	assign o_full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign o_level = count;

	// Storage and registered read port, kept simple for block RAM
	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
		if (do_read) begin
			o_rdata <= mem[rd_ptr];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

// File: hdl/sample_pacer.sv
`timescale 1ns/1ps

module sample_pacer (
	input  logic i_clock,
	input  logic i_reset,

	input  logic [audio_pkg::RELOAD_W-1:0] i_reload,

	// Queue side
	input  logic i_queue_empty,
	output logic o_queue_read,
	input  logic [audio_pkg::FRAME_W-1:0] i_frame,

	// DAC side
	output logic [audio_pkg::SAMPLE_W-1:0] o_sample_left,
	output logic [audio_pkg::SAMPLE_W-1:0] o_sample_right,
	output logic o_sample_strobe
);
	logic [audio_pkg::RELOAD_W-1:0] busy_count;
	logic busy;
	logic read_pending; // Queue output valid this cycle

	assign busy = (busy_count != '0);

	// Pop whenever the period has elapsed and a frame waits
	assign o_queue_read = !busy && !i_queue_empty;

	// Period countdown
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy_count <= '0;
		end else if (o_queue_read) begin
			busy_count <= i_reload; // Reload sampled at each pop
		end else if (busy) begin
			busy_count <= busy_count - 1'b1;
		end
	end

	// The queue read data lands one cycle after the pop
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			read_pending <= 1'b0;
		end else begin
			read_pending <= o_queue_read;
		end
	end

	// Output register and strobe
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_sample_left   <= '0;
			o_sample_right  <= '0;
			o_sample_strobe <= 1'b0;
		end else begin
			o_sample_strobe <= read_pending;
			if (read_pending) begin
				// Left channel in the upper half
				o_sample_left  <= i_frame[audio_pkg::FRAME_W-1 -: audio_pkg::SAMPLE_W];
				o_sample_right <= i_frame[audio_pkg::SAMPLE_W-1:0];
			end
		end
	end

endmodule
